// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= blit_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/blit_checker.sv ====
`timescale 1ns/100ps

module blit_checker (
    input  logic                clk,
    input  logic                busy_i,
    input  logic                full_i,
    input  logic                done_i,
    input  logic                sel_i,
    input  logic                ack_i,
    input  logic                wr_i,
    input  blit_pkg::addr_t     addr_i,
    input  blit_pkg::word_t     data_i,
    input  blit_pkg::nib_mask_t mask_i
);

    localparam int MAX_T = 16;

    blit_pkg::word_t     mem [256];            // reference copy of vram
    string               names [MAX_T];
    int                  wr_seen [MAX_T];
    int                  errs [MAX_T];
    int                  q_t [$];              // expected writes, in order
    blit_pkg::addr_t     q_a [$];
    blit_pkg::word_t     q_d [$];
    blit_pkg::nib_mask_t q_m [$];
    int                  cur;
    int                  dones;
    int                  finished;
    int                  n_pass;
    int                  n_fail;
    int                  checked;
    int                  total_errs;

    function automatic blit_pkg::word_t shift_in(input blit_pkg::word_t h,
                                                 input blit_pkg::word_t d, input int sh);
        logic [31:0] p;
        p = {h, d} >> sh;
        return p[15:0];
    endfunction

    // a nibble is opaque when it differs from the transparent value
    function automatic blit_pkg::nib_mask_t opaque(input blit_pkg::word_t b,
                                                   input logic [7:0] t, input logic is8);
        blit_pkg::nib_mask_t m;
        for (int k = 0; k < 4; k++) begin
            if (is8) begin
                m[k] = b[(k/2)*8 +: 8] != t;
            end else begin
                m[k] = b[k*4 +: 4] != t[(k%2)*4 +: 4];
            end
        end
        return m;
    endfunction

    task automatic mismatch(input int t, input string what, input logic [15:0] e,
                            input logic [15:0] a);
        $display("MISMATCH %s %s expected %h actual %h", names[t], what, e, a);
        errs[t]++;
        total_errs++;
    endtask

    task automatic set_mem(input int a, input blit_pkg::word_t w);
        mem[a] = w;
    endtask

    // reference model of one blit, run ahead of the hardware
    task automatic begin_test(input int t, input string n, input logic [15:0] ctl, shf, ma,
                              input logic [15:0] mb, mc, md, sa, sb, vc, dd, ln, wd);
        blit_pkg::addr_t     pa, pb, pd;
        blit_pkg::word_t     ca, cb, cc, ha, hb, va, vb, bp, c, d, rd;
        blit_pkg::nib_mask_t m;
        int                  sh;
        names[t] = n;
        pa = sa;
        pb = sb;
        pd = dd;
        ca = sa;
        cb = sb;
        cc = vc;
        sh = int'(shf[1:0]) * 4;
        for (int l = 0; l <= int'(ln); l++) begin
            ha = '0;                           // each line starts with empty history
            hb = '0;
            for (int w = 0; w <= int'(wd); w++) begin
                if (ctl[blit_pkg::CTRL_A_CONST_BIT]) begin
                    va = ca;
                end else begin
                    rd = mem[pa[7:0]];
                    va = shift_in(ha, rd, sh);
                    ha = rd;
                    pa = pa + 16'd1;
                end
                if (ctl[blit_pkg::CTRL_B_CONST_BIT]) begin
                    vb = cb;
                end else begin
                    rd = mem[pb[7:0]];
                    vb = shift_in(hb, rd, sh);
                    hb = rd;
                    pb = pb + 16'd1;
                end
                c  = (ctl[blit_pkg::CTRL_C_USE_B_BIT] && !ctl[blit_pkg::CTRL_B_CONST_BIT]) ?
                     vb : cc;
                bp = ctl[blit_pkg::CTRL_B_NOT_BIT] ? ~vb : vb;
                d  = (va & bp) ^ c;
                m  = opaque(vb, ctl[blit_pkg::CTRL_TRANSP_T_LSB +: 8],
                            ctl[blit_pkg::CTRL_TRANSP_8B_BIT]);
                if (w == 0) begin
                    m = m & shf[blit_pkg::SHIFT_F_MASK_LSB +: 4];
                end
                if (w == int'(wd)) begin
                    m = m & shf[blit_pkg::SHIFT_L_MASK_LSB +: 4];
                end
                q_t.push_back(t);
                q_a.push_back(pd);
                q_d.push_back(d);
                q_m.push_back(m);
                for (int k = 0; k < 4; k++) begin
                    if (m[k]) begin
                        mem[pd[7:0]][k*4 +: 4] = d[k*4 +: 4];
                    end
                end
                pd = pd + 16'd1;
            end
            pa = pa + ma;
            pb = pb + mb;
            pd = pd + md;
            ca = ca ^ ma;                      // constants flip per line
            cb = cb ^ mb;
            cc = cc ^ mc;
        end
    endtask

    always @(negedge clk) begin
        if (done_i) begin
            dones++;
        end
        if (sel_i && wr_i && ack_i) begin
            if (q_a.size() == 0) begin
                $display("unexpected VRAM write to %h with no write pending", addr_i);
                total_errs++;
            end else begin
                cur = q_t.pop_front();
                wr_seen[cur]++;
                if (addr_i !== q_a[0]) mismatch(cur, "addr", q_a[0], addr_i);
                if (data_i !== q_d[0]) mismatch(cur, "data", q_d[0], data_i);
                if (mask_i !== q_m[0]) mismatch(cur, "mask", {12'd0, q_m[0]}, {12'd0, mask_i});
                void'(q_a.pop_front());
                void'(q_d.pop_front());
                void'(q_m.pop_front());
            end
        end
    end

    task automatic check_mem(input int t, input int a, input blit_pkg::word_t act);
        if (act !== mem[a]) begin
            mismatch(t, $sformatf("mem[%0h]", a), mem[a], act);
        end
    endtask

    task automatic check_full(input int t, input logic e);
        if (full_i !== e) mismatch(t, "full after REG_WORDS", {15'd0, e}, {15'd0, full_i});
    endtask

    task automatic check_idle(input int t, input string what);
        if ({busy_i, full_i, done_i, sel_i, wr_i} !== 5'b0) begin
            mismatch(t, what, 16'h0, {11'd0, busy_i, full_i, done_i, sel_i, wr_i});
        end
    endtask

    task automatic finish_test(input int t, input int exp);
        finished++;
        if (wr_seen[t] != exp) begin
            $display("test %s saw %0d VRAM writes instead of %0d", names[t], wr_seen[t], exp);
            errs[t]++;
            total_errs++;
        end
        if (dones != finished) begin
            $display("test %s: %0d done pulses after %0d blits", names[t], dones, finished);
            errs[t]++;
            total_errs++;
        end
        checked += wr_seen[t];
        if (errs[t] == 0) n_pass++;
        else n_fail++;
        $display("test %-10s %0d writes, %0d errors", names[t], wr_seen[t], errs[t]);
    endtask

    task automatic report_totals();
        $display("%0d tests, %0d passed, %0d failed, %0d writes checked, %0d errors",
                 finished, n_pass, n_fail, checked, total_errs);
    endtask

endmodule

// ==== bench/blit_tb.sv ====
`timescale 1ns/100ps

module blit_tb;

    localparam int NT        = 14;
    localparam int MEM_WORDS = 256;

    logic                clk;
    logic                reset_i;
    logic                reg_wr;
    logic [3:0]          reg_num;
    blit_pkg::word_t     reg_data;
    logic                busy;
    logic                full;
    logic                done;
    logic                vram_sel;
    logic                vram_ack;
    logic                vram_wr;
    blit_pkg::nib_mask_t vram_mask;
    blit_pkg::addr_t     vram_addr;
    blit_pkg::word_t     vram_rdata;
    blit_pkg::word_t     vram_wdata;
    blit_pkg::word_t     vram [MEM_WORDS];
    logic                pl_en;                // preload port of the vram model
    logic [7:0]          pl_addr;
    blit_pkg::word_t     pl_data;
    string               names [NT];
    logic [15:0]         tbl [NT][12];         // register values in register-number order
    bit                  chain [NT];           // next row is queued while this one runs
    int                  exp_wr [NT];
    int                  n_rows;
    int                  limit;
    int                  cycles;
    int                  last;
    logic [15:0]         lfsr;

    blit_top UUT (
        .clk, .reset_i, .reg_wr_i (reg_wr), .reg_num_i (reg_num), .reg_data_i (reg_data),
        .busy_o (busy), .full_o (full), .done_intr_o (done),
        .vram_sel_o (vram_sel), .vram_ack_i (vram_ack), .vram_wr_o (vram_wr),
        .vram_mask_o (vram_mask), .vram_addr_o (vram_addr),
        .vram_data_i (vram_rdata), .vram_data_o (vram_wdata)
    );

    blit_checker u_chk (
        .clk, .busy_i (busy), .full_i (full), .done_i (done), .sel_i (vram_sel),
        .ack_i (vram_ack), .wr_i (vram_wr), .addr_i (vram_addr), .data_i (vram_wdata),
        .mask_i (vram_mask)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // vram answers every access one cycle after select
    always @(posedge clk) begin
        if (pl_en) vram[pl_addr] <= pl_data;
        if (reset_i) vram_ack <= 1'b0;
        else vram_ack <= vram_sel && !vram_ack;
        if (vram_sel && !vram_ack) vram_rdata <= vram[vram_addr[7:0]];
        if (vram_sel && vram_wr && vram_ack) begin
            for (int n = 0; n < 4; n++) begin
                if (vram_mask[n]) vram[vram_addr[7:0]][n*4 +: 4] <= vram_wdata[n*4 +: 4];
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, blit never finished", cycles);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic row(input string n, input bit ch, input int nwr,
                       input int ctl, shf, ma, mb, mc, md, sa, sb, vc, dd, ln, wd);
        int r [12];
        r = '{ctl, shf, ma, mb, mc, md, sa, sb, vc, dd, ln, wd};
        for (int k = 0; k < 12; k++) tbl[n_rows][k] = r[k][15:0];
        names[n_rows]  = n;
        chain[n_rows]  = ch;
        exp_wr[n_rows] = nwr;
        n_rows++;
    endtask

    task automatic load_memory();
        blit_pkg::word_t w;
        for (int a = 0; a < MEM_WORDS; a++) begin
            for (int b = 0; b < 16; b++) begin
                lfsr = lfsr_next(lfsr);
                w = {w[14:0], lfsr[0]};
            end
            @(posedge clk);
            pl_en   <= 1'b1;
            pl_addr <= a[7:0];
            pl_data <= w;
            u_chk.set_mem(a, w);
        end
        @(posedge clk);
        pl_en <= 1'b0;
    endtask

    task automatic start_blit(input int i);
        u_chk.begin_test(i, names[i], tbl[i][0], tbl[i][1], tbl[i][2], tbl[i][3], tbl[i][4],
                         tbl[i][5], tbl[i][6], tbl[i][7], tbl[i][8], tbl[i][9], tbl[i][10],
                         tbl[i][11]);
        for (int k = 0; k < 12; k++) begin     // REG_WORDS comes last and queues the blit
            @(posedge clk);
            reg_wr   <= 1'b1;
            reg_num  <= k[3:0];
            reg_data <= tbl[i][k];
        end
        @(posedge clk);
        reg_wr <= 1'b0;
        @(negedge clk);
        u_chk.check_full(i, 1'b1);
    endtask

    initial begin
        reset_i    = 1'b1;
        reg_wr     = 1'b0;
        reg_num    = '0;
        reg_data   = '0;
        vram_ack   = 1'b0;
        vram_rdata = '0;
        pl_en      = 1'b0;
        pl_addr    = '0;
        pl_data    = '0;
        lfsr       = 16'd76;
        //   name     chain wr  ctrl     shift    modA     modB     modC     modD  srcA
        //   srcB     valC     dst     lines words
        row("copy",     0,  8, 'h0002, 'hFF00, 0,       0,       0,       0,    'h10,
            'hFFFF,  0,       'h80,   0,    7);
        row("and_xor",  0,  6, 'h5A00, 'hFF00, 0,       0,       0,       0,    'h20,
            'h40,    'h3C3C,  'h90,   0,    5);
        row("b_not",    0,  6, 'h5A04, 'hFF00, 0,       0,       0,       0,    'h20,
            'h40,    'h3C3C,  'h90,   0,    5);
        row("c_use_b",  0,  6, 'h5A08, 'hFF00, 0,       0,       0,       0,    'h20,
            'h40,    'h3C3C,  'h90,   0,    5);
        row("not_useb", 0,  6, 'h5A0C, 'hFF00, 0,       0,       0,       0,    'h20,
            'h40,    'h3C3C,  'h90,   0,    5);
        row("shift1",   0,  8, 'h0002, 'h7C01, 2,       0,       0,       1,    'h10,
            'hFFFF,  0,       'h60,   1,    3);
        row("shift2",   0,  8, 'h0002, 'h7C02, 2,       0,       0,       1,    'h10,
            'hFFFF,  0,       'h60,   1,    3);
        row("shift3",   0,  8, 'h0000, 'h7C03, 2,       1,       0,       1,    'h10,
            'h30,    0,       'h60,   1,    3);
        row("transp4",  0,  6, 'h3702, 'hFF00, 0,       'h0050,  0,       2,    'h20,
            'h3A37,  'h1111,  'hA0,   1,    2);
        row("transp8",  0,  6, 'h3722, 'hFF00, 0,       'h0D00,  0,       2,    'h20,
            'h3757,  0,       'hA0,   1,    2);
        row("mod_const", 0, 12, 'h0003, 'hFF00, 'h0F0F, 'h00F0,  'h8000,  4,    'h1234,
            'hFFFF,  1,       'hA0,   3,    2);
        row("mod_reads", 0,  6, 'h0000, 'hFF00, 3,       1,       'h1111,  6,    'h30,
            'h50,    'h0F0F,  'hC0,   2,    1);
        row("queue_1",  1,  8, 'h0002, 'hFF00, 0,       0,       0,       1,    'h10,
            'hFFFF,  0,       'h70,   1,    3);
        row("queue_2",  0,  8, 'h0000, 'hFF01, 1,       1,       0,       1,    'h70,
            'h20,    'hFFFF,  'hD0,   1,    3);
        limit = 200;
        for (int i = 0; i < n_rows; i++) begin
            limit += (int'(tbl[i][10]) + 1) * (int'(tbl[i][11]) + 1) * 3 * 2;
            limit += (int'(tbl[i][10]) + 1) * 4 + 2 * MEM_WORDS + 60;
        end
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        u_chk.check_idle(0, "status after reset");
        for (int i = 0; i < n_rows; i = last + 1) begin
            load_memory();
            start_blit(i);
            last = i;
            if (chain[i]) begin
                do @(negedge clk); while (full || !busy);   // first blit now active
                start_blit(i + 1);
                last = i + 1;
            end
            for (int j = i; j <= last; j++) begin
                do @(negedge clk); while (done !== 1'b1);
                @(posedge clk);
                if (j == last) begin
                    for (int a = 0; a < MEM_WORDS; a++) u_chk.check_mem(j, a, vram[a]);
                    @(negedge clk);
                    u_chk.check_idle(j, "status after blit");
                end
                u_chk.finish_test(j, exp_wr[j]);
            end
        end
        u_chk.report_totals();
        if (u_chk.total_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/blit_pkg.sv
src/blit_regs.sv
src/blit_ctrl.sv
src/blit_source.sv
src/blit_logic.sv
src/blit_top.sv
bench/blit_checker.sv
bench/blit_tb.sv

// ==== src/blit_ctrl.sv ====
`timescale 1ns/100ps

module blit_ctrl (
    input  logic                clk,
    input  logic                reset_i,
    input  blit_pkg::blit_cfg_t cfg_i,
    input  logic                queued_i,
    input  logic                vram_ack_i,
    output logic                setup_o,
    output logic                step_o,
    output logic                rd_a_o,
    output logic                rd_b_o,
    output logic                line_start_o,
    output logic                line_end_o,
    output logic                last_word_o,
    output logic                first_word_o,
    output logic                vram_sel_o,
    output logic                vram_wr_o,
    output blit_pkg::addr_t     vram_addr_o,
    output logic                busy_o,
    output logic                done_intr_o
);

    typedef enum logic [2:0] {
        IDLE, SETUP, LINE_BEG, RD_A, RD_B, WR_D, LINE_END
    } state_t;

    state_t          state;
    state_t          acc_state;               // next access of a word
    blit_pkg::addr_t acc_addr;
    blit_pkg::addr_t ptr_a, ptr_b, ptr_d;
    blit_pkg::addr_t a_base, b_base, d_base;
    blit_pkg::addr_t addr_inc;
    blit_pkg::word_t line_cnt;                // bit 15 flags the last line
    logic [16:0]     word_cnt;                // bit 16 flags the last word
    logic            first_line;              // active copy not yet in the pointers

    assign step_o       = !vram_sel_o || vram_ack_i;
    assign setup_o      = step_o && (state == SETUP);
    assign rd_a_o       = step_o && (state == RD_A);
    assign rd_b_o       = step_o && (state == RD_B);
    assign line_start_o = step_o && (state == LINE_BEG);
    assign line_end_o   = step_o && (state == LINE_END);
    assign last_word_o  = word_cnt[16];
    assign busy_o       = (state != IDLE);
    assign done_intr_o  = (state == LINE_END) && line_cnt[15];

    assign addr_inc = vram_addr_o + 1'b1;
    assign a_base   = first_line ? cfg_i.src_a : ptr_a;
    assign b_base   = first_line ? cfg_i.src_b : ptr_b;
    assign d_base   = first_line ? cfg_i.dst_d : (state == WR_D) ? addr_inc : ptr_d;

    // first access of a word, from line begin or after a write
    always_comb begin
        if (!cfg_i.a_const) begin
            acc_state = RD_A;
            acc_addr  = a_base;
        end else if (!cfg_i.b_const) begin
            acc_state = RD_B;
            acc_addr  = b_base;
        end else begin
            acc_state = WR_D;
            acc_addr  = d_base;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= IDLE;
            vram_sel_o   <= 1'b0;
            vram_wr_o    <= 1'b0;
            first_line   <= 1'b0;
            first_word_o <= 1'b0;
        end else if (step_o) begin
            case (state)
                IDLE: begin
                    if (queued_i) begin
                        state <= SETUP;
                    end
                end
                SETUP: begin
                    first_line <= 1'b1;
                    state      <= LINE_BEG;
                end
                LINE_BEG: begin
                    first_line   <= 1'b0;
                    first_word_o <= 1'b1;
                    ptr_a        <= a_base;
                    ptr_b        <= b_base;
                    ptr_d        <= d_base;
                    line_cnt     <= (first_line ? cfg_i.lines : line_cnt) - 1'b1;
                    word_cnt     <= {1'b0, cfg_i.words} - 1'b1;
                    vram_sel_o   <= 1'b1;
                    vram_wr_o    <= (acc_state == WR_D);
                    vram_addr_o  <= acc_addr;
                    state        <= acc_state;
                end
                RD_A: begin
                    ptr_a <= addr_inc;
                    if (!cfg_i.b_const) begin
                        vram_addr_o <= ptr_b;
                        state       <= RD_B;
                    end else begin
                        vram_wr_o   <= 1'b1;
                        vram_addr_o <= ptr_d;
                        state       <= WR_D;
                    end
                end
                RD_B: begin
                    ptr_b       <= addr_inc;
                    vram_wr_o   <= 1'b1;
                    vram_addr_o <= ptr_d;
                    state       <= WR_D;
                end
                WR_D: begin
                    ptr_d        <= addr_inc;
                    word_cnt     <= word_cnt - 1'b1;
                    first_word_o <= 1'b0;
                    if (word_cnt[16]) begin   // line done
                        vram_sel_o <= 1'b0;
                        vram_wr_o  <= 1'b0;
                        state      <= LINE_END;
                    end else begin
                        vram_wr_o   <= (acc_state == WR_D);
                        vram_addr_o <= acc_addr;
                        state       <= acc_state;
                    end
                end
                LINE_END: begin
                    ptr_a <= ptr_a + cfg_i.mod_a;
                    ptr_b <= ptr_b + cfg_i.mod_b;
                    ptr_d <= ptr_d + cfg_i.mod_d;
                    if (!line_cnt[15]) begin
                        state <= LINE_BEG;
                    end else if (queued_i) begin
                        state <= SETUP;     // queued blit follows at once
                    end else begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_bus_stable: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o && !vram_ack_i |=> $stable(vram_addr_o) && $stable(vram_wr_o));

    a_done_pulse: assert property (@(posedge clk) disable iff (reset_i)
        done_intr_o |=> !done_intr_o);

endmodule

// ==== src/blit_logic.sv ====
`timescale 1ns/100ps

module blit_logic (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                load_i,
    input  logic                step_i,
    input  logic                rd_b_i,
    input  logic                line_end_i,
    input  logic                last_word_i,
    input  blit_pkg::blit_cfg_t cfg_i,
    input  blit_pkg::word_t     val_a_i,
    input  blit_pkg::word_t     val_b_i,
    input  logic                first_word_i,
    output blit_pkg::word_t     vram_data_o,
    output blit_pkg::nib_mask_t vram_mask_o
);

    logic                load_q;
    logic                c_is_b;               // C follows the last B read
    blit_pkg::word_t     c_reg;
    blit_pkg::word_t     c_op;
    blit_pkg::word_t     b_prime;
    blit_pkg::nib_mask_t t4, t8;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            load_q <= 1'b0;
            c_is_b <= 1'b0;
        end else begin
            load_q <= load_i;
            if (load_q) begin
                c_is_b <= 1'b0;
            end else if (step_i && rd_b_i) begin
                c_is_b <= cfg_i.c_use_b;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_q) begin
            c_reg <= cfg_i.val_c;
        end else if (step_i && line_end_i) begin
            c_reg <= c_reg ^ cfg_i.mod_c;
        end
    end

    assign c_op        = c_is_b ? val_b_i : c_reg;
    assign b_prime     = cfg_i.b_not ? ~val_b_i : val_b_i;
    assign vram_data_o = val_a_i & b_prime ^ c_op;

    // a nibble is written unless it matches the transparent value
    always_comb begin
        for (int i = 0; i < blit_pkg::WORD_W / blit_pkg::NIB_W; i++) begin
            t4[i] = val_b_i[i*blit_pkg::NIB_W +: blit_pkg::NIB_W] !=
                    cfg_i.transp_t[(i%2)*blit_pkg::NIB_W +: blit_pkg::NIB_W];
            t8[i] = val_b_i[(i/2)*8 +: 8] != cfg_i.transp_t;
        end
    end

    assign vram_mask_o = (first_word_i ? cfg_i.f_mask : 4'b1111) &
                         (last_word_i ? cfg_i.l_mask : 4'b1111) &
                         (cfg_i.transp_8b ? t8 : t4);

endmodule

// ==== src/blit_pkg.sv ====
package blit_pkg;

    localparam int WORD_W = 16;
    localparam int NIB_W  = 4;

    typedef logic [WORD_W-1:0] word_t;       // vram data word
    typedef logic [15:0]       addr_t;       // vram word address
    typedef logic [3:0]        nib_mask_t;   // bit 3 is the top nibble

    // register numbers on the 4-bit register port
    localparam logic [3:0] REG_CTRL  = 4'd0;
    localparam logic [3:0] REG_SHIFT = 4'd1;
    localparam logic [3:0] REG_MOD_A = 4'd2;
    localparam logic [3:0] REG_MOD_B = 4'd3;
    localparam logic [3:0] REG_MOD_C = 4'd4;
    localparam logic [3:0] REG_MOD_D = 4'd5;
    localparam logic [3:0] REG_SRC_A = 4'd6;
    localparam logic [3:0] REG_SRC_B = 4'd7;
    localparam logic [3:0] REG_VAL_C = 4'd8;
    localparam logic [3:0] REG_DST_D = 4'd9;
    localparam logic [3:0] REG_LINES = 4'd10;   // line count minus one
    localparam logic [3:0] REG_WORDS = 4'd11;   // words per line minus one, queues the blit

    localparam int CTRL_A_CONST_BIT   = 0;
    localparam int CTRL_B_CONST_BIT   = 1;
    localparam int CTRL_B_NOT_BIT     = 2;
    localparam int CTRL_C_USE_B_BIT   = 3;
    localparam int CTRL_TRANSP_8B_BIT = 5;
    localparam int CTRL_TRANSP_T_LSB  = 8;

    localparam int SHIFT_F_MASK_LSB = 12;
    localparam int SHIFT_L_MASK_LSB = 8;
    localparam int SHIFT_AMT_W      = 2;

    typedef struct packed {
        logic                   a_const;
        logic                   b_const;
        logic                   b_not;
        logic                   c_use_b;
        logic                   transp_8b;
        logic [7:0]             transp_t;      // transparent pixel value
        logic [SHIFT_AMT_W-1:0] shift_amt;     // right shift in nibbles
        nib_mask_t              f_mask;
        nib_mask_t              l_mask;
        word_t                  mod_a;
        word_t                  mod_b;
        word_t                  mod_c;
        word_t                  mod_d;
        word_t                  src_a;         // address, or constant when a_const
        word_t                  src_b;
        word_t                  val_c;
        word_t                  dst_d;
        word_t                  lines;
        word_t                  words;
    } blit_cfg_t;

endpackage

// ==== src/blit_regs.sv ====
`timescale 1ns/100ps

module blit_regs (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                reg_wr_i,
    input  logic [3:0]          reg_num_i,
    input  blit_pkg::word_t     reg_data_i,
    input  logic                setup_i,       // copy queue into active set
    output blit_pkg::blit_cfg_t cfg_o,
    output logic                full_o
);

    blit_pkg::blit_cfg_t q;                    // queued blit

    always_ff @(posedge clk) begin
        if (reset_i) begin
            q      <= '0;
            full_o <= 1'b0;
        end else begin
            if (setup_i) begin
                full_o <= 1'b0;
            end
            if (reg_wr_i) begin
                case (reg_num_i)
                    blit_pkg::REG_CTRL: begin
                        q.a_const   <= reg_data_i[blit_pkg::CTRL_A_CONST_BIT];
                        q.b_const   <= reg_data_i[blit_pkg::CTRL_B_CONST_BIT];
                        q.b_not     <= reg_data_i[blit_pkg::CTRL_B_NOT_BIT];
                        q.c_use_b   <= reg_data_i[blit_pkg::CTRL_C_USE_B_BIT];
                        q.transp_8b <= reg_data_i[blit_pkg::CTRL_TRANSP_8B_BIT];
                        q.transp_t  <= reg_data_i[blit_pkg::CTRL_TRANSP_T_LSB +: 8];
                    end
                    blit_pkg::REG_SHIFT: begin
                        q.f_mask    <= reg_data_i[blit_pkg::SHIFT_F_MASK_LSB +: blit_pkg::NIB_W];
                        q.l_mask    <= reg_data_i[blit_pkg::SHIFT_L_MASK_LSB +: blit_pkg::NIB_W];
                        q.shift_amt <= reg_data_i[0 +: blit_pkg::SHIFT_AMT_W];
                    end
                    blit_pkg::REG_MOD_A: q.mod_a <= reg_data_i;
                    blit_pkg::REG_MOD_B: q.mod_b <= reg_data_i;
                    blit_pkg::REG_MOD_C: q.mod_c <= reg_data_i;
                    blit_pkg::REG_MOD_D: q.mod_d <= reg_data_i;
                    blit_pkg::REG_SRC_A: q.src_a <= reg_data_i;
                    blit_pkg::REG_SRC_B: q.src_b <= reg_data_i;
                    blit_pkg::REG_VAL_C: q.val_c <= reg_data_i;
                    blit_pkg::REG_DST_D: q.dst_d <= reg_data_i;
                    blit_pkg::REG_LINES: q.lines <= reg_data_i;
                    blit_pkg::REG_WORDS: begin
                        q.words <= reg_data_i;
                        full_o  <= 1'b1;       // wins over a setup in the same cycle
                    end
                    default: ;
                endcase
            end
        end
    end

    // active copy, read by the engine from line begin on
    always_ff @(posedge clk) begin
        if (setup_i) begin
            cfg_o <= q;
        end
    end

    // the engine only takes a blit that has been queued
    a_setup_needs_full: assert property (
        @(posedge clk) disable iff (reset_i) setup_i |-> full_o);

endmodule

// ==== src/blit_source.sv ====
`timescale 1ns/100ps

module blit_source (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             step_i,
    input  logic                             load_i,
    input  logic                             rd_i,
    input  logic                             line_start_i,
    input  logic                             line_end_i,
    input  blit_pkg::word_t                  const_init_i,
    input  blit_pkg::word_t                  mod_i,
    input  logic [blit_pkg::SHIFT_AMT_W-1:0] shift_amt_i,
    input  blit_pkg::word_t                  data_i,
    output blit_pkg::word_t                  val_o
);

    logic                            load_q;   // active copy is valid one cycle after setup
    blit_pkg::word_t                 hist;     // previous word of this line
    logic [2*blit_pkg::WORD_W-1:0]   pair;

    // low nibbles of the history fill in from the left
    assign pair = {hist, data_i} >> (shift_amt_i * blit_pkg::NIB_W);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            load_q <= 1'b0;
        end else begin
            load_q <= load_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load_q) begin
            val_o <= const_init_i;
            hist  <= '0;
        end else if (step_i) begin
            if (rd_i) begin
                val_o <= pair[blit_pkg::WORD_W-1:0];
                hist  <= data_i;
            end else if (line_start_i) begin
                hist  <= '0;                   // defined first word per line
            end else if (line_end_i) begin
                val_o <= val_o ^ mod_i;
            end
        end
    end

endmodule

// ==== src/blit_top.sv ====
`timescale 1ns/100ps

module blit_top (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                reg_wr_i,
    input  logic [3:0]          reg_num_i,
    input  blit_pkg::word_t     reg_data_i,
    output logic                busy_o,
    output logic                full_o,
    output logic                done_intr_o,
    output logic                vram_sel_o,
    input  logic                vram_ack_i,
    output logic                vram_wr_o,
    output blit_pkg::nib_mask_t vram_mask_o,
    output blit_pkg::addr_t     vram_addr_o,
    input  blit_pkg::word_t     vram_data_i,
    output blit_pkg::word_t     vram_data_o
);

    blit_pkg::blit_cfg_t cfg;
    blit_pkg::word_t     val_a, val_b;
    logic setup, step, rd_a, rd_b;
    logic line_start, line_end, last_word, first_word;

    blit_regs u_regs (
        .clk, .reset_i, .reg_wr_i, .reg_num_i, .reg_data_i,
        .setup_i (setup), .cfg_o (cfg), .full_o
    );

    blit_ctrl u_ctrl (
        .clk, .reset_i, .cfg_i (cfg), .queued_i (full_o), .vram_ack_i,
        .setup_o (setup), .step_o (step), .rd_a_o (rd_a), .rd_b_o (rd_b),
        .line_start_o (line_start), .line_end_o (line_end),
        .last_word_o (last_word), .first_word_o (first_word),
        .vram_sel_o, .vram_wr_o, .vram_addr_o, .busy_o, .done_intr_o
    );

    blit_source u_src_a (
        .clk, .reset_i, .step_i (step), .load_i (setup), .rd_i (rd_a),
        .line_start_i (line_start), .line_end_i (line_end),
        .const_init_i (cfg.src_a), .mod_i (cfg.mod_a), .shift_amt_i (cfg.shift_amt),
        .data_i (vram_data_i), .val_o (val_a)
    );

    blit_source u_src_b (
        .clk, .reset_i, .step_i (step), .load_i (setup), .rd_i (rd_b),
        .line_start_i (line_start), .line_end_i (line_end),
        .const_init_i (cfg.src_b), .mod_i (cfg.mod_b), .shift_amt_i (cfg.shift_amt),
        .data_i (vram_data_i), .val_o (val_b)
    );

    blit_logic u_logic (
        .clk, .reset_i, .load_i (setup), .step_i (step), .rd_b_i (rd_b),
        .line_end_i (line_end), .last_word_i (last_word), .cfg_i (cfg),
        .val_a_i (val_a), .val_b_i (val_b), .first_word_i (first_word),
        .vram_data_o, .vram_mask_o
    );

endmodule
